// File: Makefile
# Verilator build and run of the UART echo testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --top-module uart_echo_tb -f vlog.f -o uart_echo_sim
	./obj_dir/uart_echo_sim | tee $(LOG)
	@if grep -qx "test passed" $(LOG); then \
		echo "simulation result: PASS"; \
	else \
		echo "simulation result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: tb/uart_echo_tb.sv
// UART echo testbench
// serial driver, frame monitor and display checks
module uart_echo_tb;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int CLKS_PER_BIT = 16;                 // bit time in clocks
    localparam int FRAME_CLKS   = 10 * CLKS_PER_BIT;  // start, 8 data, stop
    localparam int ECHO_WAIT    = 3 * FRAME_CLKS;     // longest wait for one echo
    localparam int MAX_CYCLES   = 20000;              // 25 frames of 160 with margin
    localparam logic [31:0] RAND_SEED = 32'h48caacd7;

    logic       clk     = 1'b0;
    logic       rst     = 1'b1;
    logic       uart_rx = 1'b1;                       // line idles high
    logic       uart_tx;
    logic       tx_active;
    logic [6:0] seg_hi_n;
    logic [6:0] seg_lo_n;

    logic [7:0] echo_q[$];                            // bytes seen on o_uart_tx
    int         echo_rd        = 0;                   // next echo to compare
    int         value_errors   = 0;
    int         missing_errors = 0;
    int         frame_errors   = 0;                   // bad start or stop on tx
    int         active_cycles  = 0;                   // cycles with o_tx_active high
    int         cycle_cnt      = 0;

    uart_echo_top #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) dut_i (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_uart_rx   (uart_rx),
        .o_uart_tx   (uart_tx),
        .o_tx_active (tx_active),
        .o_seg_hi_n  (seg_hi_n),
        .o_seg_lo_n  (seg_lo_n)
    );

    always #50 clk = ~clk;                            // 100 ns period

    // run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout after %0d cycles with tests still running", cycle_cnt);
            $display("test failed");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (tx_active) begin
            active_cycles <= active_cycles + 1;
        end
    end

    // recovers frames from o_uart_tx by centre sampling
    initial begin : tx_monitor
        logic [7:0] shift;
        forever begin
            @(negedge clk);
            if (!rst && (uart_tx == 1'b0)) begin
                repeat (CLKS_PER_BIT / 2) @(negedge clk);    // middle of start bit
                if (uart_tx != 1'b0) begin
                    $display("start bit on o_uart_tx went high before its middle");
                    frame_errors++;
                end
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    shift[i] = uart_tx;               // lsb first
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                if (uart_tx != 1'b1) begin
                    $display("stop bit on o_uart_tx is not high for byte 0x%02h", shift);
                    frame_errors++;
                end
                echo_q.push_back(shift);
            end
        end
    end

    // expected active-low glyph, bits a to g
    function automatic logic [6:0] glyph_n(input logic [3:0] nibble);
        logic [6:0] on;
        case (nibble)
            4'h0: on = 7'b1111110;
            4'h1: on = 7'b0110000;
            4'h2: on = 7'b1101101;
            4'h3: on = 7'b1111001;
            4'h4: on = 7'b0110011;
            4'h5: on = 7'b1011011;
            4'h6: on = 7'b1011111;
            4'h7: on = 7'b1110000;
            4'h8: on = 7'b1111111;
            4'h9: on = 7'b1111011;
            4'hA: on = 7'b1110111;
            4'hB: on = 7'b0011111;                    // b
            4'hC: on = 7'b1001110;
            4'hD: on = 7'b0111101;                    // d
            4'hE: on = 7'b1001111;
            default: on = 7'b1000111;                 // F
        endcase
        return ~on;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            value_errors++;
        end
    endtask

    task automatic send_bit(input logic bit_val);
        @(negedge clk);
        uart_rx = bit_val;
        repeat (CLKS_PER_BIT - 1) @(negedge clk);     // held for one bit time
    endtask

    task automatic send_byte(input logic [7:0] data);
        send_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            send_bit(data[i]);
        end
        send_bit(1'b1);
    endtask

    task automatic expect_echo(input logic [7:0] expected);
        int waited;
        waited = 0;
        while ((echo_q.size() <= echo_rd) && (waited < ECHO_WAIT)) begin
            @(negedge clk);
            waited++;
        end
        if (echo_q.size() <= echo_rd) begin
            $display("echo of byte 0x%02h did not arrive within %0d cycles", expected, waited);
            missing_errors++;
        end else begin
            check_value("o_uart_tx byte", 32'(echo_q[echo_rd]), 32'(expected));
            echo_rd++;
        end
    endtask

    task automatic check_display(input logic [3:0] hi, input logic [3:0] lo);
        check_value("o_seg_hi_n", 32'(seg_hi_n), 32'(glyph_n(hi)));
        check_value("o_seg_lo_n", 32'(seg_lo_n), 32'(glyph_n(lo)));
    endtask

    task automatic verify_reset_state();
        check_value("o_uart_tx", 32'(uart_tx), 32'd1);
        check_value("o_tx_active", 32'(tx_active), 32'd0);
        check_display(4'h0, 4'h0);
    endtask

    task automatic echo_single_byte();
        send_byte(8'hA5);
        expect_echo(8'hA5);
        check_display(4'hA, 4'h5);
    endtask

    // a low pulse shorter than half a bit is not a start bit
    task automatic reject_short_glitch();
        int seen;
        seen = echo_q.size();
        @(negedge clk);
        uart_rx = 1'b0;
        repeat (4) @(negedge clk);
        uart_rx = 1'b1;
        repeat (ECHO_WAIT) @(negedge clk);
        if (echo_q.size() != seen) begin
            $display("a short glitch on i_uart_rx produced an echo");
            missing_errors++;
            echo_rd = echo_q.size();                  // skip the spurious byte
        end
        check_display(4'hA, 4'h5);
    endtask

    task automatic echo_back_to_back();
        logic [7:0] sent[8];
        int         active_before;
        active_before = active_cycles;
        for (int i = 0; i < 8; i++) begin
            sent[i] = 8'($urandom);
        end
        for (int i = 0; i < 8; i++) begin
            send_byte(sent[i]);                       // no idle between frames
        end
        for (int i = 0; i < 8; i++) begin
            expect_echo(sent[i]);
        end
        check_value("o_tx_active", 32'(active_cycles > active_before), 32'd1);
    endtask

    task automatic show_all_nibbles();
        logic [3:0] hi;
        logic [3:0] lo;
        for (int n = 0; n < 16; n++) begin
            hi = 4'(n);
            lo = 4'(15 - n);
            send_byte({hi, lo});
            expect_echo({hi, lo});
            check_display(hi, lo);
        end
    endtask

    initial begin
        void'($urandom(RAND_SEED));
        rst     = 1'b1;
        uart_rx = 1'b1;
        repeat (2) @(negedge clk);                    // two reset cycles
        rst = 1'b0;
        repeat (2) @(negedge clk);                    // segment registers settle
        verify_reset_state();
        echo_single_byte();
        reject_short_glitch();
        echo_back_to_back();
        show_all_nibbles();
        $display("errors: %0d wrong value, %0d missing echo, %0d bad frame",
                 value_errors, missing_errors, frame_errors);
        if ((value_errors + missing_errors + frame_errors) == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: verilog/hex_to_7seg.sv
// Hex digit decoder
module hex_to_7seg (
    input  logic       i_clk,
    input  logic [3:0] i_nibble,              // value 0 to F
    output logic [6:0] o_seg_n                // segment a on bit 6 down to g on bit 0
);

    logic [6:0] seg;                          // active-high glyph

    always_comb begin
        case (i_nibble)
            4'h0: seg = 7'h7E;
            4'h1: seg = 7'h30;
            4'h2: seg = 7'h6D;
            4'h3: seg = 7'h79;
            4'h4: seg = 7'h33;
            4'h5: seg = 7'h5B;
            4'h6: seg = 7'h5F;
            4'h7: seg = 7'h70;
            4'h8: seg = 7'h7F;
            4'h9: seg = 7'h7B;
            4'hA: seg = 7'h77;
            4'hB: seg = 7'h1F;                // lower-case b
            4'hC: seg = 7'h4E;
            4'hD: seg = 7'h3D;                // lower-case d
            4'hE: seg = 7'h4F;
            4'hF: seg = 7'h47;
            default: seg = 7'h00;
        endcase
    end

    // common-anode display lights a segment on a low output
    always_ff @(posedge i_clk) begin
        o_seg_n <= ~seg;
    end

endmodule

// File: verilog/uart_echo_top.sv
// UART echo top level
// receiver, one-byte hold, transmitter, hex display
module uart_echo_top #(
    parameter int CLKS_PER_BIT = 217          // 115200 baud at 25 MHz
) (
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_uart_rx,             // serial in, idles high
    output logic       o_uart_tx,             // serial out, idles high
    output logic       o_tx_active,           // echo frame on the wire
    output logic [6:0] o_seg_hi_n,            // high nibble, active low
    output logic [6:0] o_seg_lo_n             // low nibble, active low
);
    import uart_pkg::*;

    uart_byte_t  rx_byte;                     // receiver output
    uart_byte_t  pend_q;                      // byte waiting for the transmitter
    logic [7:0]  disp_q;                      // last received byte
    logic        tx_done;                     // transmitter finished a frame
    logic        tx_free;                     // transmitter can take a strobe
    logic        tx_start;                    // strobe into transmitter
    logic [7:0]  tx_byte;                     // byte with the strobe
    logic        direct_send;                 // rx byte goes straight out

    uart_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) rx_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_rx_serial (i_uart_rx),
        .o_rx        (rx_byte)
    );

    // no strobe during the done pulse since the FSM is in cleanup
    assign tx_free     = !o_tx_active && !tx_done;
    // pending byte is older so it goes first
    assign tx_start    = tx_free && (pend_q.valid || rx_byte.valid);
    assign tx_byte     = pend_q.valid ? pend_q.data : rx_byte.data;
    assign direct_send = tx_free && !pend_q.valid;

    // one-entry hold register
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pend_q.valid <= 1'b0;
        end else if (rx_byte.valid && !direct_send) begin
            pend_q.valid <= 1'b1;             // a full entry is overwritten
            pend_q.data  <= rx_byte.data;
        end else if (tx_start && pend_q.valid) begin
            pend_q.valid <= 1'b0;             // handed to the transmitter
        end
    end

    // display shows the newest byte
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            disp_q <= 8'h00;
        end else if (rx_byte.valid) begin
            disp_q <= rx_byte.data;
        end
    end

    uart_tx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) tx_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_tx_start  (tx_start),
        .i_tx_byte   (tx_byte),
        .o_tx_serial (o_uart_tx),
        .o_tx_active (o_tx_active),
        .o_tx_done   (tx_done)
    );

    hex_to_7seg seg_hi_i (
        .i_clk    (i_clk),
        .i_nibble (disp_q[7:4]),
        .o_seg_n  (o_seg_hi_n)
    );

    hex_to_7seg seg_lo_i (
        .i_clk    (i_clk),
        .i_nibble (disp_q[3:0]),
        .o_seg_n  (o_seg_lo_n)
    );

endmodule

// File: verilog/uart_pkg.sv
// UART shared types
// frame constants and state encodings
package uart_pkg;

    // 8N1 frame with lsb first
    localparam int DATA_BITS = 8;        // data bits per frame

    // one received byte and its strobe
    typedef struct packed {
        logic       valid;               // one-cycle strobe
        logic [7:0] data;                // byte as received
    } uart_byte_t;

    // receiver FSM
    typedef enum logic [2:0] {
        RX_IDLE    = 3'd0,               // waiting for line to drop
        RX_START   = 3'd1,               // counting to middle of start bit
        RX_DATA    = 3'd2,               // sampling eight data bits
        RX_STOP    = 3'd3,               // waiting to middle of stop bit
        RX_CLEANUP = 3'd4                // drop valid then back to idle
    } rx_state_e;

    // transmitter FSM
    typedef enum logic [2:0] {
        TX_IDLE    = 3'd0,               // line high and waiting for strobe
        TX_START   = 3'd1,               // start bit low
        TX_DATA    = 3'd2,               // eight data bits
        TX_STOP    = 3'd3,               // stop bit high
        TX_CLEANUP = 3'd4                // done pulse cycle
    } tx_state_e;

endpackage

// File: verilog/uart_rx.sv
// UART receiver
// 8N1 with centre sampling
module uart_rx #(
    parameter int CLKS_PER_BIT = 217          // clock cycles per serial bit
) (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_rx_serial,  // serial line, idles high
    output uart_pkg::uart_byte_t o_rx          // valid strobes once per byte
);
    import uart_pkg::*;

    // counter wide enough to hold CLKS_PER_BIT-1
    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam int IDX_W = $clog2(DATA_BITS);

    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(CLKS_PER_BIT - 1);         // one full bit
    localparam logic [CNT_W-1:0] CNT_MID = CNT_W'((CLKS_PER_BIT - 1) / 2);   // half a bit
    localparam logic [IDX_W-1:0] IDX_MAX = IDX_W'(DATA_BITS - 1);            // last data bit

    rx_state_e              state_q;          // receiver FSM
    logic [CNT_W-1:0]       cnt_q;            // cycles within current bit
    logic [IDX_W-1:0]       idx_q;            // data bit being sampled
    logic                   rx_q;             // line after one register stage
    logic                   valid_q;          // byte strobe
    logic [DATA_BITS-1:0]   shift_q;          // assembled byte
    logic                   sample_en;        // centre of a data bit

    // data bits are taken at the end of each full-bit count
    assign sample_en = (state_q == RX_DATA) && (cnt_q == CNT_MAX);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state_q <= RX_IDLE;
            cnt_q   <= '0;
            idx_q   <= '0;
            rx_q    <= 1'b1;                  // treat line as idle
            valid_q <= 1'b0;
        end else begin
            rx_q <= i_rx_serial;              // single register stage on the pin
            case (state_q)
                RX_IDLE: begin
                    valid_q <= 1'b0;
                    cnt_q   <= '0;
                    idx_q   <= '0;
                    if (!rx_q) begin          // falling edge of start bit
                        state_q <= RX_START;
                    end
                end

                RX_START: begin
                    if (cnt_q == CNT_MID) begin
                        cnt_q <= '0;          // now aligned to bit centres
                        if (!rx_q) begin
                            state_q <= RX_DATA;
                        end else begin
                            state_q <= RX_IDLE;   // glitch, not a real start
                        end
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end

                RX_DATA: begin
                    if (cnt_q == CNT_MAX) begin
                        cnt_q <= '0;
                        if (idx_q == IDX_MAX) begin
                            idx_q   <= '0;
                            state_q <= RX_STOP;
                        end else begin
                            idx_q <= idx_q + 1'b1;
                        end
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end

                RX_STOP: begin
                    // stop level is not checked
                    if (cnt_q == CNT_MAX) begin
                        cnt_q   <= '0;
                        valid_q <= 1'b1;      // middle of stop bit
                        state_q <= RX_CLEANUP;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end

                RX_CLEANUP: begin
                    valid_q <= 1'b0;          // strobe lasts one cycle
                    state_q <= RX_IDLE;
                end

                default: begin
                    state_q <= RX_IDLE;
                end
            endcase
        end
    end

    // lsb arrives first so shift in from the top
    always_ff @(posedge i_clk) begin
        if (sample_en) begin
            shift_q <= {rx_q, shift_q[DATA_BITS-1:1]};
        end
    end

    assign o_rx.valid = valid_q;
    assign o_rx.data  = shift_q;              // stable until next frame shifts in

endmodule

// File: verilog/uart_tx.sv
// UART transmitter
// 8N1 frame out
module uart_tx #(
    parameter int CLKS_PER_BIT = 217          // clock cycles per serial bit
) (
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_tx_start,            // one-cycle strobe
    input  logic [7:0] i_tx_byte,             // taken with the strobe
    output logic       o_tx_serial,           // serial line, idles high
    output logic       o_tx_active,           // start bit through stop bit
    output logic       o_tx_done              // pulse after stop bit
);
    import uart_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam int IDX_W = $clog2(DATA_BITS);

    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(CLKS_PER_BIT - 1);   // last cycle of a bit
    localparam logic [IDX_W-1:0] IDX_MAX = IDX_W'(DATA_BITS - 1);

    tx_state_e              state_q;          // transmitter FSM
    logic [CNT_W-1:0]       cnt_q;            // cycles within current bit
    logic [IDX_W-1:0]       idx_q;            // data bit on the line
    logic [DATA_BITS-1:0]   byte_q;           // latched byte
    logic                   load_en;          // accept a new byte

    assign load_en = (state_q == TX_IDLE) && i_tx_start;

    always_ff @(posedge i_clk) begin
        if (load_en) begin
            byte_q <= i_tx_byte;
        end
    end

    // line is registered so each bit lasts exactly CLKS_PER_BIT cycles
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state_q     <= TX_IDLE;
            cnt_q       <= '0;
            idx_q       <= '0;
            o_tx_serial <= 1'b1;
            o_tx_active <= 1'b0;
            o_tx_done   <= 1'b0;
        end else begin
            case (state_q)
                TX_IDLE: begin
                    o_tx_serial <= 1'b1;
                    o_tx_done   <= 1'b0;
                    cnt_q       <= '0;
                    idx_q       <= '0;
                    if (i_tx_start) begin
                        o_tx_serial <= 1'b0;  // start bit next cycle
                        o_tx_active <= 1'b1;
                        state_q     <= TX_START;
                    end
                end

                TX_START: begin
                    if (cnt_q == CNT_MAX) begin
                        cnt_q       <= '0;
                        o_tx_serial <= byte_q[0];     // lsb first
                        state_q     <= TX_DATA;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end

                TX_DATA: begin
                    if (cnt_q == CNT_MAX) begin
                        cnt_q <= '0;
                        if (idx_q == IDX_MAX) begin
                            idx_q       <= '0;
                            o_tx_serial <= 1'b1;      // stop bit
                            state_q     <= TX_STOP;
                        end else begin
                            idx_q       <= idx_q + 1'b1;
                            o_tx_serial <= byte_q[idx_q + 1'b1];
                        end
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end

                TX_STOP: begin
                    if (cnt_q == CNT_MAX) begin
                        cnt_q       <= '0;
                        o_tx_done   <= 1'b1;
                        o_tx_active <= 1'b0;  // falls with done
                        state_q     <= TX_CLEANUP;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end

                TX_CLEANUP: begin
                    o_tx_done <= 1'b0;        // ready for a new strobe next cycle
                    state_q   <= TX_IDLE;
                end

                default: begin
                    state_q <= TX_IDLE;
                end
            endcase
        end
    end

endmodule

// File: vlog.f
verilog/uart_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/hex_to_7seg.sv
verilog/uart_echo_top.sv
tb/uart_echo_tb.sv
